/* verilog/vaddr_pkg.sv */
// Widths, limits and encodings shared by the vector address generator
// Payload structs carried by the request and descriptor queues
`default_nettype none

package vaddr_pkg;

  ////////////////////////////////////////
  // Widths and limits
  ////////////////////////////////////////

  // Byte address
  localparam int unsigned AddrWidth = 32;
  typedef logic [AddrWidth-1:0] addr_t;

  // Element count of one instruction
  localparam int unsigned VlWidth = 16;
  typedef logic [VlWidth-1:0] vlen_t;

  // Byte stride, may be negative
  typedef logic signed [AddrWidth-1:0] stride_t;

  // 4 KiB page, a burst never crosses it
  localparam int unsigned PageBits = 12;

  // Longest incrementing burst in beats
  localparam int unsigned MaxBurstBeats = 256;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Value is log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Unit-stride and strided loads and stores
  typedef enum logic [1:0] {
    OP_VLE  = 2'd0,
    OP_VSE  = 2'd1,
    OP_VLSE = 2'd2,
    OP_VSSE = 2'd3
  } vop_e;

  ////////////////////////////////////////
  // Queue payloads
  ////////////////////////////////////////

  // One decoded instruction, waiting for the splitter
  typedef struct packed {
    addr_t   addr;
    vlen_t   len;
    stride_t stride;
    vew_e    vew;
    logic    is_load;
    // Unit-stride, turned into incrementing bursts
    logic    is_burst;
  } mem_req_t;

  // One address request as seen by the load/store units
  typedef struct packed {
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    logic       is_load;
  } lsu_req_t;

endpackage

`default_nettype wire

/* verilog/vaddr_fifo.sv */
// Synchronous FIFO built on a register array
// Payload type set by a type parameter
`timescale 1ns/1ps
`default_nettype none

module vaddr_fifo #(
  parameter int unsigned Depth = 4,
  parameter type         T     = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  T     data_i,
  output logic full_o,
  input  logic pop_i,
  output T     data_o,
  output logic empty_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  // Storage and bookkeeping
  T                    mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                do_push;
  logic                do_pop;

  // Pointer wraps at Depth, which need not be a power of two
  function automatic logic [PtrWidth-1:0] ptr_inc(logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + PtrWidth'(1);
  endfunction

  assign full_o  = (count_q == CntWidth'(Depth));
  assign empty_o = (count_q == '0);

  // Push on full and pop on empty are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Head entry, valid whenever the queue is not empty
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Count moves only when one side is active
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + CntWidth'(1);
        2'b01:   count_q <= count_q - CntWidth'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/vaddr_req_decode.sv */
// Instruction intake with a one-entry holding register
// Alignment and length check, acknowledge, push into the request queue
`timescale 1ns/1ps
`default_nettype none

module vaddr_req_decode (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Instruction port
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  vaddr_pkg::vop_e     req_op_i,
  input  vaddr_pkg::addr_t    req_addr_i,
  input  vaddr_pkg::vlen_t    req_len_i,
  input  vaddr_pkg::stride_t  req_stride_i,
  input  vaddr_pkg::vew_e     req_vew_i,
  // Acknowledge
  output logic                ack_o,
  output logic                ack_error_o,
  // Request queue
  input  logic                queue_full_i,
  output logic                queue_push_o,
  output vaddr_pkg::mem_req_t queue_data_o
);

  ////////////////////////////////////////
  // Holding register
  ////////////////////////////////////////

  logic                busy_q;
  vaddr_pkg::mem_req_t entry_q;
  logic                accept;

  // Ready while nothing is held
  assign req_ready_o = !busy_q;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (accept) begin
      busy_q <= 1'b1;
    end else if (ack_o) begin
      // Free again in the cycle after the ack
      busy_q <= 1'b0;
    end
  end

  // Queue entry built at intake
  always_ff @(posedge clk_i) begin
    if (accept) begin
      entry_q.addr     <= req_addr_i;
      entry_q.len      <= req_len_i;
      entry_q.stride   <= req_stride_i;
      entry_q.vew      <= req_vew_i;
      entry_q.is_load  <= (req_op_i == vaddr_pkg::OP_VLE) ||
                          (req_op_i == vaddr_pkg::OP_VLSE);
      // Unit-stride ops become bursts
      entry_q.is_burst <= (req_op_i == vaddr_pkg::OP_VLE) ||
                          (req_op_i == vaddr_pkg::OP_VSE);
    end
  end

  ////////////////////////////////////////
  // Checks and acknowledge
  ////////////////////////////////////////

  vaddr_pkg::addr_t align_mask;
  logic             misaligned;
  logic             zero_len;
  logic             reject;

  // Address bits below the element size must be zero
  assign align_mask = (vaddr_pkg::addr_t'(1) << entry_q.vew) - vaddr_pkg::addr_t'(1);
  assign misaligned = |(entry_q.addr & align_mask);
  assign zero_len   = (entry_q.len == '0);

  // Nothing is issued for these, only the ack
  assign reject = misaligned || zero_len;

  // Good entries wait for room in the queue
  assign queue_push_o = busy_q && !reject && !queue_full_i;
  assign queue_data_o = entry_q;

  // Ack in the push cycle, or at once for a rejected entry
  assign ack_o       = busy_q && (reject || !queue_full_i);
  // Zero length is acknowledged without error
  assign ack_error_o = busy_q && misaligned;

endmodule

`default_nettype wire

/* verilog/vaddr_burst_split.sv */
// Splits queued memory requests into AR/AW address requests
// Unit-stride becomes page and length bounded bursts, strided one beat per element
// Every transfer is mirrored into the load/store descriptor queue
`timescale 1ns/1ps
`default_nettype none

module vaddr_burst_split #(
  parameter int unsigned BusBytes = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Request queue
  input  logic                 req_empty_i,
  input  vaddr_pkg::mem_req_t  req_data_i,
  output logic                 req_pop_o,
  // AR channel
  output logic                 ar_valid_o,
  input  logic                 ar_ready_i,
  output vaddr_pkg::addr_t     ar_addr_o,
  output logic [7:0]           ar_len_o,
  output logic [2:0]           ar_size_o,
  // AW channel
  output logic                 aw_valid_o,
  input  logic                 aw_ready_i,
  output vaddr_pkg::addr_t     aw_addr_o,
  output logic [7:0]           aw_len_o,
  output logic [2:0]           aw_size_o,
  // Descriptor queue
  input  logic                 lsu_full_i,
  input  logic                 lsu_empty_i,
  input  logic                 lsu_head_is_load_i,
  output logic                 lsu_push_o,
  output vaddr_pkg::lsu_req_t  lsu_data_o
);

  localparam int unsigned ByteOff = $clog2(BusBytes);
  // Byte offset bits inside one bus beat
  localparam vaddr_pkg::addr_t BeatMask  = vaddr_pkg::addr_t'(BusBytes - 1);
  localparam vaddr_pkg::addr_t BurstSpan =
    vaddr_pkg::addr_t'(vaddr_pkg::MaxBurstBeats * BusBytes);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BOUNDS,
    ST_REQ
  } state_e;

  state_e              state_q;
  vaddr_pkg::mem_req_t cur_q;
  vaddr_pkg::addr_t    aligned_start_q;
  vaddr_pkg::addr_t    aligned_end_q;
  vaddr_pkg::addr_t    next_start_q;

  ////////////////////////////////////////
  // Next element and burst bounds
  ////////////////////////////////////////

  vaddr_pkg::addr_t consumed_bytes;
  vaddr_pkg::addr_t consumed_elems;
  vaddr_pkg::addr_t next_addr;
  vaddr_pkg::vlen_t next_len;
  vaddr_pkg::addr_t bnd_addr;
  vaddr_pkg::vlen_t bnd_len;
  vaddr_pkg::addr_t bnd_bytes;
  vaddr_pkg::addr_t last_byte;
  vaddr_pkg::addr_t page_end;
  vaddr_pkg::addr_t burst_end;
  vaddr_pkg::addr_t end_sel;

  // Bytes covered by the current burst, from the element address on
  assign consumed_bytes = next_start_q - cur_q.addr;
  assign consumed_elems = consumed_bytes >> cur_q.vew;

  // Address and count after the current request is sent
  always_comb begin
    if (cur_q.is_burst) begin
      next_addr = next_start_q;
      // Clamp at zero on the last burst
      if (consumed_elems >= vaddr_pkg::addr_t'(cur_q.len)) begin
        next_len = '0;
      end else begin
        next_len = cur_q.len - vaddr_pkg::vlen_t'(consumed_elems);
      end
    end else begin
      next_addr = cur_q.addr + vaddr_pkg::addr_t'(cur_q.stride);
      next_len  = cur_q.len - vaddr_pkg::vlen_t'(1);
    end
  end

  // Bounds come from the fresh entry, or from the advanced one after a transfer
  assign bnd_addr = (state_q == ST_REQ) ? next_addr : cur_q.addr;
  assign bnd_len  = (state_q == ST_REQ) ? next_len : cur_q.len;

  assign bnd_bytes = vaddr_pkg::addr_t'(bnd_len) << cur_q.vew;
  assign last_byte = bnd_addr + bnd_bytes - vaddr_pkg::addr_t'(1);
  assign page_end  = {bnd_addr[vaddr_pkg::AddrWidth-1:vaddr_pkg::PageBits],
                      {vaddr_pkg::PageBits{1'b1}}};
  assign burst_end = (bnd_addr & ~BeatMask) + BurstSpan - vaddr_pkg::addr_t'(1);

  // Smallest of request end, page end and burst limit
  always_comb begin
    end_sel = last_byte;
    if (page_end < end_sel) begin
      end_sel = page_end;
    end
    if (burst_end < end_sel) begin
      end_sel = burst_end;
    end
  end

  ////////////////////////////////////////
  // Request handshake
  ////////////////////////////////////////

  logic             dir_ok;
  logic             ax_valid;
  logic             ax_ready;
  logic             xfer;
  vaddr_pkg::addr_t beat_span;
  logic [7:0]       ax_len;
  logic [2:0]       ax_size;

  // Queue holds one direction only, so the head tells it
  assign dir_ok   = lsu_empty_i || (lsu_head_is_load_i == cur_q.is_load);
  assign ax_valid = (state_q == ST_REQ) && dir_ok && !lsu_full_i;
  assign ax_ready = cur_q.is_load ? ar_ready_i : aw_ready_i;
  assign xfer     = ax_valid && ax_ready;

  // Beats minus one of the burst
  assign beat_span = (aligned_end_q - aligned_start_q) >> ByteOff;
  assign ax_len    = cur_q.is_burst ? beat_span[7:0] : 8'd0;
  assign ax_size   = cur_q.is_burst ? 3'(ByteOff) : {1'b0, cur_q.vew};

  assign ar_valid_o = ax_valid && cur_q.is_load;
  assign ar_addr_o  = cur_q.addr;
  assign ar_len_o   = ax_len;
  assign ar_size_o  = ax_size;

  assign aw_valid_o = ax_valid && !cur_q.is_load;
  assign aw_addr_o  = cur_q.addr;
  assign aw_len_o   = ax_len;
  assign aw_size_o  = ax_size;

  // Descriptor goes out with the address transfer
  assign lsu_push_o         = xfer;
  assign lsu_data_o.addr    = cur_q.addr;
  assign lsu_data_o.len     = ax_len;
  assign lsu_data_o.size    = ax_size;
  assign lsu_data_o.is_load = cur_q.is_load;

  // Take a new entry only when idle
  assign req_pop_o = (state_q == ST_IDLE) && !req_empty_i;

  ////////////////////////////////////////
  // State and registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:   if (req_pop_o) state_q <= ST_BOUNDS;
        ST_BOUNDS: state_q <= ST_REQ;
        // Last transfer ends the request
        ST_REQ:    if (xfer && (next_len == '0)) state_q <= ST_IDLE;
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_pop_o) begin
      cur_q <= req_data_i;
    end else if (xfer) begin
      cur_q.addr <= next_addr;
      cur_q.len  <= next_len;
    end
    // Bounds for the first burst, then for each following one
    if ((state_q == ST_BOUNDS) || xfer) begin
      aligned_start_q <= bnd_addr & ~BeatMask;
      aligned_end_q   <= end_sel & ~BeatMask;
      next_start_q    <= (end_sel & ~BeatMask) + vaddr_pkg::addr_t'(BusBytes);
    end
  end

endmodule

`default_nettype wire

/* verilog/vaddr_gen.sv */
// Vector address generator top level
// Decoder, request queue, burst splitter and descriptor queue
`timescale 1ns/1ps
`default_nettype none

module vaddr_gen #(
  parameter int unsigned BusBytes = 8,
  parameter int unsigned ReqDepth = 4,
  parameter int unsigned LsuDepth = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Instruction port
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  vaddr_pkg::vop_e    req_op_i,
  input  vaddr_pkg::addr_t   req_addr_i,
  input  vaddr_pkg::vlen_t   req_len_i,
  input  vaddr_pkg::stride_t req_stride_i,
  input  vaddr_pkg::vew_e    req_vew_i,
  // Acknowledge
  output logic               ack_o,
  output logic               ack_error_o,
  // AR channel
  output logic               ar_valid_o,
  input  logic               ar_ready_i,
  output vaddr_pkg::addr_t   ar_addr_o,
  output logic [7:0]         ar_len_o,
  output logic [2:0]         ar_size_o,
  // AW channel
  output logic               aw_valid_o,
  input  logic               aw_ready_i,
  output vaddr_pkg::addr_t   aw_addr_o,
  output logic [7:0]         aw_len_o,
  output logic [2:0]         aw_size_o,
  // Load/store descriptors
  output logic               lsu_valid_o,
  input  logic               lsu_ready_i,
  output vaddr_pkg::addr_t   lsu_addr_o,
  output logic [7:0]         lsu_len_o,
  output logic [2:0]         lsu_size_o,
  output logic               lsu_is_load_o
);

  // Decoder to request queue
  logic                req_push;
  logic                req_full;
  vaddr_pkg::mem_req_t req_in;

  // Request queue to splitter
  logic                req_pop;
  logic                req_empty;
  vaddr_pkg::mem_req_t req_head;

  // Splitter to descriptor queue
  logic                lsu_push;
  logic                lsu_full;
  logic                lsu_empty;
  vaddr_pkg::lsu_req_t lsu_in;
  vaddr_pkg::lsu_req_t lsu_head;

  vaddr_req_decode u_decode (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_len_i    (req_len_i),
    .req_stride_i (req_stride_i),
    .req_vew_i    (req_vew_i),
    .ack_o        (ack_o),
    .ack_error_o  (ack_error_o),
    .queue_full_i (req_full),
    .queue_push_o (req_push),
    .queue_data_o (req_in)
  );

  vaddr_fifo #(
    .Depth (ReqDepth),
    .T     (vaddr_pkg::mem_req_t)
  ) u_req_q (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (req_push),
    .data_i  (req_in),
    .full_o  (req_full),
    .pop_i   (req_pop),
    .data_o  (req_head),
    .empty_o (req_empty)
  );

  vaddr_burst_split #(
    .BusBytes (BusBytes)
  ) u_split (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .req_empty_i        (req_empty),
    .req_data_i         (req_head),
    .req_pop_o          (req_pop),
    .ar_valid_o         (ar_valid_o),
    .ar_ready_i         (ar_ready_i),
    .ar_addr_o          (ar_addr_o),
    .ar_len_o           (ar_len_o),
    .ar_size_o          (ar_size_o),
    .aw_valid_o         (aw_valid_o),
    .aw_ready_i         (aw_ready_i),
    .aw_addr_o          (aw_addr_o),
    .aw_len_o           (aw_len_o),
    .aw_size_o          (aw_size_o),
    .lsu_full_i         (lsu_full),
    .lsu_empty_i        (lsu_empty),
    .lsu_head_is_load_i (lsu_head.is_load),
    .lsu_push_o         (lsu_push),
    .lsu_data_o         (lsu_in)
  );

  // Pop on ready, an empty queue ignores it
  vaddr_fifo #(
    .Depth (LsuDepth),
    .T     (vaddr_pkg::lsu_req_t)
  ) u_lsu_q (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (lsu_push),
    .data_i  (lsu_in),
    .full_o  (lsu_full),
    .pop_i   (lsu_ready_i),
    .data_o  (lsu_head),
    .empty_o (lsu_empty)
  );

  // Descriptor head fields
  assign lsu_valid_o   = !lsu_empty;
  assign lsu_addr_o    = lsu_head.addr;
  assign lsu_len_o     = lsu_head.len;
  assign lsu_size_o    = lsu_head.size;
  assign lsu_is_load_o = lsu_head.is_load;

endmodule

`default_nettype wire

/* dv/vaddr_gen_checker.sv */
// Protocol assertions for the vector address generator
// Bound into vaddr_gen at the end of this file
`timescale 1ns/1ps
`default_nettype none

module vaddr_gen_checker (
  input wire logic        clk_i,
  input wire logic        rst_ni,
  input wire logic        ack_o,
  input wire logic        ar_valid_o,
  input wire logic        ar_ready_i,
  input wire logic [31:0] ar_addr_o,
  input wire logic [7:0]  ar_len_o,
  input wire logic [2:0]  ar_size_o,
  input wire logic        aw_valid_o,
  input wire logic        aw_ready_i,
  input wire logic [31:0] aw_addr_o,
  input wire logic [7:0]  aw_len_o,
  input wire logic [2:0]  aw_size_o,
  input wire logic        lsu_valid_o,
  input wire logic        lsu_ready_i,
  input wire logic [31:0] lsu_addr_o,
  input wire logic [7:0]  lsu_len_o,
  input wire logic [2:0]  lsu_size_o,
  input wire logic        lsu_is_load_o
);

  // First and last byte of the burst share the page number
  function automatic logic in_one_page(logic [31:0] addr, logic [7:0] len, logic [2:0] size);
    logic [31:0] first;
    logic [31:0] last;
    first = addr & ~((32'd1 << size) - 32'd1);
    last  = first + ((32'(len) + 32'd1) << size) - 32'd1;
    return (first >> vaddr_pkg::PageBits) == (last >> vaddr_pkg::PageBits);
  endfunction

  ////////////////////////////////////////
  // Handshake stability
  ////////////////////////////////////////

  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o) &&
    $stable(ar_len_o) && $stable(ar_size_o))
    else $error("AR request dropped or changed before ready");

  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o) &&
    $stable(aw_len_o) && $stable(aw_size_o))
    else $error("AW request dropped or changed before ready");

  lsu_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_valid_o && !lsu_ready_i |=> lsu_valid_o && $stable(lsu_addr_o) &&
    $stable(lsu_len_o) && $stable(lsu_size_o) && $stable(lsu_is_load_o))
    else $error("Descriptor dropped or changed before ready");

  ////////////////////////////////////////
  // Channel rules
  ////////////////////////////////////////

  // One direction at a time
  ar_aw_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ar_valid_o && aw_valid_o))
    else $error("AR and AW valid in the same cycle");

  ar_page: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o |-> in_one_page(ar_addr_o, ar_len_o, ar_size_o))
    else $error("AR burst crosses a page boundary");

  aw_page: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o |-> in_one_page(aw_addr_o, aw_len_o, aw_size_o))
    else $error("AW burst crosses a page boundary");

  // Ack is a single-cycle pulse
  ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o |=> !ack_o)
    else $error("Ack high on two consecutive cycles");

endmodule

bind vaddr_gen vaddr_gen_checker u_checker (.*);

`default_nettype wire

/* dv/tb_vaddr_gen.sv */
// Testbench for the vector address generator
// Clock and reset, instruction stimulus, reference model, compare process
`timescale 1ns/1ps
`default_nettype none

module tb_vaddr_gen;

  localparam int unsigned BusBytes      = 8;
  localparam int unsigned NumInstr      = 21;
  localparam int unsigned ResetCycles   = 16;
  localparam int unsigned TimeoutCycles = 300 * NumInstr + ResetCycles;

  logic               clk_i;
  logic               rst_ni;
  logic               req_valid_i;
  logic               req_ready_o;
  vaddr_pkg::vop_e    req_op_i;
  vaddr_pkg::addr_t   req_addr_i;
  vaddr_pkg::vlen_t   req_len_i;
  vaddr_pkg::stride_t req_stride_i;
  vaddr_pkg::vew_e    req_vew_i;
  logic               ack_o;
  logic               ack_error_o;
  logic               ar_valid_o;
  logic               ar_ready_i;
  logic [31:0]        ar_addr_o;
  logic [7:0]         ar_len_o;
  logic [2:0]         ar_size_o;
  logic               aw_valid_o;
  logic               aw_ready_i;
  logic [31:0]        aw_addr_o;
  logic [7:0]         aw_len_o;
  logic [2:0]         aw_size_o;
  logic               lsu_valid_o;
  logic               lsu_ready_i;
  logic [31:0]        lsu_addr_o;
  logic [7:0]         lsu_len_o;
  logic [2:0]         lsu_size_o;
  logic               lsu_is_load_o;

  // Expected address requests, ack error bits, bookkeeping
  vaddr_pkg::lsu_req_t ax_q[$];
  vaddr_pkg::lsu_req_t lsu_q[$];
  logic                ack_q[$];
  int                  errors = 0;
  int                  checks = 0;
  int                  cycles = 0;
  integer              seed   = 32'he0e2;
  logic                random_ready;
  int                  i;
  vaddr_pkg::vew_e     r_vew;
  logic [31:0]         r_addr;

  vaddr_gen #(.BusBytes(BusBytes)) DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Expands one instruction into its ack bit and address requests
  function automatic void expand_instr(input vaddr_pkg::vop_e op, input logic [31:0] addr,
                                       input logic [15:0] len, input logic [31:0] stride,
                                       input vaddr_pkg::vew_e vew);
    logic [31:0]         a;
    logic [31:0]         n;
    logic [31:0]         first;
    logic [31:0]         e;
    logic [31:0]         nxt;
    logic [31:0]         used;
    logic                is_burst;
    vaddr_pkg::lsu_req_t r;
    is_burst  = (op == vaddr_pkg::OP_VLE) || (op == vaddr_pkg::OP_VSE);
    r.is_load = (op == vaddr_pkg::OP_VLE) || (op == vaddr_pkg::OP_VLSE);
    // Misaligned base, error and nothing issued
    if ((addr & ((32'd1 << vew) - 32'd1)) != 32'd0) begin
      ack_q.push_back(1'b1);
      return;
    end
    ack_q.push_back(1'b0);
    a = addr;
    n = 32'(len);
    while (n != 32'd0) begin
      r.addr = a;
      if (is_burst) begin
        first = a & ~32'(BusBytes - 1);
        // End at request end, page end or 256 beats, whichever comes first
        e = a + (n << vew) - 32'd1;
        if ((a | 32'hFFF) < e) e = a | 32'hFFF;
        if ((first + 32'(256 * BusBytes) - 32'd1) < e) e = first + 32'(256 * BusBytes) - 32'd1;
        e      = e & ~32'(BusBytes - 1);
        r.len  = 8'((e - first) / BusBytes);
        r.size = 3'($clog2(BusBytes));
        nxt    = e + 32'(BusBytes);
        used   = (nxt - a) >> vew;
        n      = (used >= n) ? 32'd0 : n - used;
        a      = nxt;
      end else begin
        // One element per beat
        r.len  = 8'd0;
        r.size = {1'b0, vew};
        a      = a + stride;
        n      = n - 32'd1;
      end
      ax_q.push_back(r);
      lsu_q.push_back(r);
    end
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Called 1 ns after a rising edge, returns at the same phase
  task automatic send_instr(input vaddr_pkg::vop_e op, input logic [31:0] addr,
                            input logic [15:0] len, input logic [31:0] stride,
                            input vaddr_pkg::vew_e vew);
    logic taken;
    expand_instr(op, addr, len, stride, vew);
    req_valid_i  = 1'b1;
    req_op_i     = op;
    req_addr_i   = addr;
    req_len_i    = len;
    req_stride_i = stride;
    req_vew_i    = vew;
    taken        = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = req_ready_o;
      @(posedge clk_i);
    end
    #1;
    req_valid_i = 1'b0;
  endtask

  // Ready inputs, all high or random per cycle
  always @(posedge clk_i) begin
    #1;
    if (random_ready) begin
      ar_ready_i  = ($random(seed) % 4) != 0;
      aw_ready_i  = ($random(seed) % 4) != 0;
      lsu_ready_i = ($random(seed) & 1) != 0;
    end else begin
      ar_ready_i  = 1'b1;
      aw_ready_i  = 1'b1;
      lsu_ready_i = 1'b1;
    end
  end

  ////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////

  task automatic match_request(input string ch, input logic [31:0] addr, input logic [7:0] len,
                               input logic [2:0] size, input logic is_load, input bit from_lsu);
    vaddr_pkg::lsu_req_t e;
    if ((from_lsu && lsu_q.size() == 0) || (!from_lsu && ax_q.size() == 0)) begin
      errors++;
      $display("Unexpected %s request at address 0x%08h", ch, addr);
    end else begin
      if (from_lsu) e = lsu_q.pop_front();
      else e = ax_q.pop_front();
      check_eq({ch, "_addr_o"}, addr, e.addr);
      check_eq({ch, "_len_o"}, 32'(len), 32'(e.len));
      check_eq({ch, "_size_o"}, 32'(size), 32'(e.size));
      check_eq(from_lsu ? "lsu_is_load_o" : {ch, "_valid_o"}, 32'(is_load), 32'(e.is_load));
    end
  endtask

  // Sampled at the falling edge, between input drive and the next rising edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      // No request while the other direction is still unread
      if (ar_valid_o && lsu_valid_o) check_eq("lsu_is_load_o", 32'(lsu_is_load_o), 32'd1);
      if (aw_valid_o && lsu_valid_o) check_eq("lsu_is_load_o", 32'(lsu_is_load_o), 32'd0);
      if (ar_valid_o && ar_ready_i) begin
        match_request("ar", ar_addr_o, ar_len_o, ar_size_o, 1'b1, 1'b0);
      end
      if (aw_valid_o && aw_ready_i) begin
        match_request("aw", aw_addr_o, aw_len_o, aw_size_o, 1'b0, 1'b0);
      end
      if (lsu_valid_o && lsu_ready_i) begin
        match_request("lsu", lsu_addr_o, lsu_len_o, lsu_size_o, lsu_is_load_o, 1'b1);
      end
      if (ack_o) begin
        if (ack_q.size() == 0) begin
          errors++;
          $display("Unexpected ack with no instruction pending");
        end else begin
          check_eq("ack_error_o", 32'(ack_error_o), 32'(ack_q.pop_front()));
        end
      end
    end
  end

  // Run limit
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout, the run did not finish within %0d cycles", TimeoutCycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    rst_ni       = 1'b0;
    random_ready = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = vaddr_pkg::OP_VLE;
    req_addr_i   = '0;
    req_len_i    = '0;
    req_stride_i = '0;
    req_vew_i    = vaddr_pkg::EW8;
    ar_ready_i   = 1'b0;
    aw_ready_i   = 1'b0;
    lsu_ready_i  = 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // State right after reset
    @(negedge clk_i);
    check_eq("req_ready_o", 32'(req_ready_o), 32'd1);
    check_eq("ack_o", 32'(ack_o), 32'd0);
    check_eq("ar_valid_o", 32'(ar_valid_o), 32'd0);
    check_eq("aw_valid_o", 32'(aw_valid_o), 32'd0);
    check_eq("lsu_valid_o", 32'(lsu_valid_o), 32'd0);
    @(posedge clk_i);
    #1;
    // Unit-stride load inside one page
    send_instr(vaddr_pkg::OP_VLE, 32'h0000_1000, 16'd16, 32'd0, vaddr_pkg::EW32);
    // Page crossing, then the 256 beat limit, then an unaligned bus start
    send_instr(vaddr_pkg::OP_VSE, 32'h0000_1FC0, 16'd32, 32'd0, vaddr_pkg::EW32);
    send_instr(vaddr_pkg::OP_VSE, 32'h0000_4000, 16'd600, 32'd0, vaddr_pkg::EW64);
    send_instr(vaddr_pkg::OP_VLE, 32'h0000_2FF4, 16'd10, 32'd0, vaddr_pkg::EW16);
    // Strided, positive and negative
    send_instr(vaddr_pkg::OP_VLSE, 32'h0000_8000, 16'd5, 32'd24, vaddr_pkg::EW32);
    send_instr(vaddr_pkg::OP_VSSE, 32'h0000_9100, 16'd4, -32'sd16, vaddr_pkg::EW64);
    // Misaligned bases and a zero length
    send_instr(vaddr_pkg::OP_VLE, 32'h0000_1002, 16'd4, 32'd0, vaddr_pkg::EW32);
    send_instr(vaddr_pkg::OP_VSSE, 32'h0000_1001, 16'd4, 32'd2, vaddr_pkg::EW16);
    send_instr(vaddr_pkg::OP_VLE, 32'h0000_1000, 16'd0, 32'd0, vaddr_pkg::EW32);
    // Alternating loads and stores under back-pressure
    random_ready = 1'b1;
    for (i = 0; i < 12; i++) begin
      r_vew  = vaddr_pkg::vew_e'(2'($random(seed)));
      r_addr = 32'($random(seed)) & 32'h0FFF_FFFF & ~((32'd1 << r_vew) - 32'd1);
      send_instr(vaddr_pkg::vop_e'(2'(i)), r_addr, 16'(($random(seed) & 31) + 1),
                 (32'($random(seed) & 15) - 32'd8) << r_vew, r_vew);
    end
    // Drain, then a few idle cycles to catch stray requests
    while (ack_q.size() != 0 || ax_q.size() != 0 || lsu_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (10) @(posedge clk_i);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* Bender.yml */
package:
  name: vaddr_gen

sources:
  - verilog/vaddr_pkg.sv
  - verilog/vaddr_fifo.sv
  - verilog/vaddr_req_decode.sv
  - verilog/vaddr_burst_split.sv
  - verilog/vaddr_gen.sv
  - target: test
    files:
      - dv/vaddr_gen_checker.sv
      - dv/tb_vaddr_gen.sv

/* vaddr_gen.f */
verilog/vaddr_pkg.sv
verilog/vaddr_fifo.sv
verilog/vaddr_req_decode.sv
verilog/vaddr_burst_split.sv
verilog/vaddr_gen.sv
dv/vaddr_gen_checker.sv
dv/tb_vaddr_gen.sv
